// File: rtl/cmt_unit.sv
`include "ncpu64k_params.svh"

module cmt_unit
   import ncpu_cmt_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  cmt_entry_t [`CMT_W-1:0] ent,
   input  logic                    stall,
   input  logic                    irq_pend,
   output logic                    cmt_p_ce_s1,
   output logic                    irq_ack,
   output cmt_rec_t                cmt
);

   cmt_rec_t   rec_nxt;
   exc_cause_e cause;

   function automatic logic [31:0] exc_vect(exc_cause_e c);
      return `EXC_VECT_BASE + {26'd0, c, 4'd0};
   endfunction

   assign cmt_p_ce_s1 = ~stall;

   always_comb
   begin
      rec_nxt = '0;
      cause = NONE;
      irq_ack = 1'b0;
      for (int i = 0; i < `CMT_W; i++)
      begin
         rec_nxt.pc[i] = ent[i].pc;
         rec_nxt.lrd[i] = ent[i].lrd;
         rec_nxt.lrd_dat[i] = ent[i].lrd_dat;
      end
      if (cmt_p_ce_s1 && ent[0].valid)
      begin
         if (irq_pend)
         begin
            // Interrupt replaces the oldest instruction
            cause = IRQ;
            irq_ack = 1'b1;
         end
         else if (ent[0].cause != NONE)
         begin
            cause = ent[0].cause;
         end
         else
         begin
            rec_nxt.fire[0] = 1'b1;
            rec_nxt.lrd_we[0] = ent[0].lrd_we;
            if (ent[1].valid)
            begin
               if (ent[1].cause != NONE)
               begin
                  cause = ent[1].cause;
               end
               else
               begin
                  rec_nxt.fire[1] = 1'b1;
                  rec_nxt.lrd_we[1] = ent[1].lrd_we;
               end
            end
         end
      end
      rec_nxt.exc = (cause != NONE);
      rec_nxt.exc_vect = exc_vect(cause);
   end

   always_ff @(posedge clk)
   begin
      cmt <= rec_nxt;
      if (rst)
      begin
         cmt.fire <= '0;
         cmt.lrd_we <= '0;
         cmt.exc <= 1'b0;
      end
   end

   // An exception cycle never retires the younger lane
   a_exc_no_lane1 : assert property (@(posedge clk) disable iff (rst)
      !(cmt.exc && cmt.fire[1]));

   // Retire stays in program order
   a_in_order : assert property (@(posedge clk) disable iff (rst)
      cmt.fire[1] |-> cmt.fire[0]);

endmodule

// File: rtl/commit_tracer.sv
`include "ncpu64k_params.svh"

module commit_tracer
   import difftest_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  dt_rec_t                  dt,
   input  logic [`NCPU_LRF_AW-1:0]  rf_raddr,
   output logic [`CONFIG_DW-1:0]    rf_rdat,
   output trace_stat_t              stat
);

   logic [`CONFIG_DW-1:0] shadow_rf [`NCPU_LRF_N];

   // Lanes in order, so the younger write to a register lands last
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int r = 0; r < `NCPU_LRF_N; r++)
            shadow_rf[r] <= '0;
      end
      else
      begin
         for (int i = 0; i < `CMT_W; i++)
         begin
            if (dt.cmt.fire[i] && dt.cmt.lrd_we[i])
               shadow_rf[dt.cmt.lrd[i]] <= dt.cmt.lrd_dat[i];
         end
      end
   end

   assign rf_rdat = shadow_rf[rf_raddr];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         stat <= '0;
      end
      else
      begin
         stat.commit_cnt <= stat.commit_cnt + 32'($countones(dt.cmt.fire));
         if (dt.cmt.exc)
         begin
            stat.exc_cnt <= stat.exc_cnt + 16'd1;
            stat.last_exc_vect <= dt.cmt.exc_vect;
            stat.last_irr <= dt.irqc_irr;
         end
      end
   end

endmodule

// File: rtl/difftest.sv
`include "ncpu64k_params.svh"

module difftest
   import ncpu_cmt_pkg::*;
   import difftest_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  cmt_rec_t                    cmt,
   input  logic                        cmt_p_ce_s1,
   input  logic [`CONFIG_NUM_IRQ-1:0]  msr_irqc_irr,
   output dt_rec_t                     dt
);

   logic [`CONFIG_NUM_IRQ-1:0] s1o_msr_irqc_irr;

   // Requests as the commit unit saw them on its last enabled edge
   always_ff @(posedge clk)
   begin
      if (cmt_p_ce_s1)
         s1o_msr_irqc_irr <= msr_irqc_irr;
   end

   // Trace tap, one cycle behind the commit record
   always_ff @(posedge clk)
   begin
      dt.cmt <= cmt;
      dt.irqc_irr <= s1o_msr_irqc_irr;
      if (rst)
      begin
         dt.cmt.fire <= '0;
         dt.cmt.lrd_we <= '0;
      end
   end

endmodule

// File: rtl/difftest_pkg.sv
`include "ncpu64k_params.svh"

package difftest_pkg;

   import ncpu_cmt_pkg::*;

   // Commit record as seen by the trace, with the interrupt snapshot
   typedef struct packed
   {
      cmt_rec_t                    cmt;
      logic [`CONFIG_NUM_IRQ-1:0]  irqc_irr;
   } dt_rec_t;

   typedef struct packed
   {
      logic [31:0]                 commit_cnt;
      logic [15:0]                 exc_cnt;
      logic [31:0]                 last_exc_vect;
      logic [`CONFIG_NUM_IRQ-1:0]  last_irr;
   } trace_stat_t;

endpackage

// File: rtl/irq_ctrl.sv
`include "ncpu64k_params.svh"

module irq_ctrl
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        cmt_p_ce_s1,
   input  logic [`CONFIG_NUM_IRQ-1:0]  irq,
   input  logic                        irq_ack,
   input  logic                        msr_we,
   input  logic [`CONFIG_NUM_IRQ-1:0]  msr_wdat,
   output logic [`CONFIG_NUM_IRQ-1:0]  irqc_irr,
   output logic                        irq_pend
);

   logic [`CONFIG_NUM_IRQ-1:0] imr;

   // Sticky requests, taken lines cleared on ack
   always_ff @(posedge clk)
   begin
      if (rst)
         irqc_irr <= '0;
      else if (cmt_p_ce_s1)
         irqc_irr <= (irqc_irr & ~({`CONFIG_NUM_IRQ{irq_ack}} & imr)) | irq;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         imr <= '0;
      else if (msr_we)
         imr <= msr_wdat;
   end

   assign irq_pend = |(irqc_irr & imr);

   // Commit unit only takes an interrupt that is pending here
   a_ack_needs_pend : assert property (@(posedge clk) disable iff (rst)
      irq_ack |-> irq_pend);

endmodule

// File: rtl/ncpu64k_params.svh
`ifndef NCPU64K_PARAMS_SVH
`define NCPU64K_PARAMS_SVH

// Word address, byte offset dropped
`define PC_W 30

`define CONFIG_DW 32

// Logical register file
`define NCPU_LRF_AW 5
`define NCPU_LRF_N 32

// Commit lanes per cycle
`define CMT_W 2

`define CONFIG_NUM_IRQ 8

// Vector of a cause is base + cause * 16
`define EXC_VECT_BASE 32'h0000_0100

`endif

// File: rtl/ncpu_cmt_pkg.sv
`include "ncpu64k_params.svh"

package ncpu_cmt_pkg;

   typedef enum logic [1:0]
   {
      NONE    = 2'd0,
      ILLEGAL = 2'd1,
      SYSCALL = 2'd2,
      IRQ     = 2'd3
   } exc_cause_e;

   // One completed instruction from the back end
   typedef struct packed
   {
      logic                        valid;
      logic [`PC_W-1:0]            pc;
      logic [`NCPU_LRF_AW-1:0]     lrd;
      logic                        lrd_we;
      logic [`CONFIG_DW-1:0]       lrd_dat;
      exc_cause_e                  cause;
   } cmt_entry_t;

   // One commit cycle, all lanes
   typedef struct packed
   {
      logic [`CMT_W-1:0]                        fire;
      logic [`CMT_W-1:0][`PC_W-1:0]             pc;
      logic [`CMT_W-1:0][`NCPU_LRF_AW-1:0]      lrd;
      logic [`CMT_W-1:0][`CONFIG_DW-1:0]        lrd_dat;
      logic [`CMT_W-1:0]                        lrd_we;
      logic                                     exc;
      logic [31:0]                              exc_vect;
   } cmt_rec_t;

endpackage

// File: rtl/ncpu_commit_top.sv
`include "ncpu64k_params.svh"

module ncpu_commit_top
   import ncpu_cmt_pkg::*;
   import difftest_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  cmt_entry_t [`CMT_W-1:0]     ent,
   input  logic                        stall,
   input  logic [`CONFIG_NUM_IRQ-1:0]  irq,
   input  logic                        msr_we,
   input  logic [`CONFIG_NUM_IRQ-1:0]  msr_wdat,
   input  logic [`NCPU_LRF_AW-1:0]     rf_raddr,
   output logic [`CONFIG_DW-1:0]       rf_rdat,
   output trace_stat_t                 stat,
   output cmt_rec_t                    cmt
);

   logic                       cmt_p_ce_s1;
   logic [`CONFIG_NUM_IRQ-1:0] irqc_irr;
   logic                       irq_pend;
   logic                       irq_ack;
   dt_rec_t                    dt;

   irq_ctrl u_irq_ctrl
   (
      .clk         (clk),
      .rst         (rst),
      .cmt_p_ce_s1 (cmt_p_ce_s1),
      .irq         (irq),
      .irq_ack     (irq_ack),
      .msr_we      (msr_we),
      .msr_wdat    (msr_wdat),
      .irqc_irr    (irqc_irr),
      .irq_pend    (irq_pend)
   );

   cmt_unit u_cmt_unit
   (
      .clk         (clk),
      .rst         (rst),
      .ent         (ent),
      .stall       (stall),
      .irq_pend    (irq_pend),
      .cmt_p_ce_s1 (cmt_p_ce_s1),
      .irq_ack     (irq_ack),
      .cmt         (cmt)
   );

   difftest u_difftest
   (
      .clk          (clk),
      .rst          (rst),
      .cmt          (cmt),
      .cmt_p_ce_s1  (cmt_p_ce_s1),
      .msr_irqc_irr (irqc_irr),
      .dt           (dt)
   );

   commit_tracer u_commit_tracer
   (
      .clk      (clk),
      .rst      (rst),
      .dt       (dt),
      .rf_raddr (rf_raddr),
      .rf_rdat  (rf_rdat),
      .stat     (stat)
   );

endmodule

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" &&
   verilator --binary --assert -f vlog.f --top-module tb_ncpu_commit &&
   ./obj_dir/Vtb_ncpu_commit | tee /dev/stderr | grep -F "Result: PASSED" > /dev/null &&
   echo "Simulation passed" ||
   { echo "Simulation failed"; exit 1; }

// File: test/tb_ncpu_commit.sv
`include "ncpu64k_params.svh"

module tb_ncpu_commit
   import ncpu_cmt_pkg::*;
   import difftest_pkg::*;
();

   // All tests together need well under 500 cycles
   localparam int TIMEOUT_CYCLES = 2000;

   logic                        clk;
   logic                        rst;
   cmt_entry_t [`CMT_W-1:0]     ent;
   logic                        stall;
   logic [`CONFIG_NUM_IRQ-1:0]  irq;
   logic                        msr_we;
   logic [`CONFIG_NUM_IRQ-1:0]  msr_wdat;
   logic [`NCPU_LRF_AW-1:0]     rf_raddr;
   logic [`CONFIG_DW-1:0]       rf_rdat;
   trace_stat_t                 stat;
   cmt_rec_t                    cmt;

   // Expected trace state
   logic [31:0]       exp_rf [`NCPU_LRF_N];
   logic [31:0]       exp_commit;
   logic [31:0]       exp_exc;
   logic [31:0]       exp_vect;
   logic [31:0]       exp_irr;
   logic [`CMT_W-1:0] seen_fire;
   logic              seen_exc;
   int                err_cnt;
   int                test_cnt;
   int                test_fail;
   int                cycle_cnt;

   ncpu_commit_top uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("The run timed out after %0d cycles", cycle_cnt);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic next_edge();
      @(posedge clk);
      #1;
   endtask

   task automatic check(string what, logic [31:0] got, logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   function automatic cmt_entry_t build_entry(logic valid, logic [31:0] r, logic we,
                                              logic [31:0] dat, exc_cause_e cause);
      cmt_entry_t  e;
      logic [31:0] pc_rnd;
      pc_rnd = $urandom;
      e.valid = valid;
      e.pc = pc_rnd[`PC_W-1:0];
      e.lrd = r[`NCPU_LRF_AW-1:0];
      e.lrd_we = we;
      e.lrd_dat = dat;
      e.cause = cause;
      return e;
   endfunction

   // Entry pair sampled on one edge, trace settled two edges later
   task automatic commit_pair(cmt_entry_t e0, cmt_entry_t e1);
      next_edge();
      ent[0] = e0;
      ent[1] = e1;
      next_edge();
      seen_fire = cmt.fire;
      seen_exc = cmt.exc;
      check("cmt.pc[0]", 32'(cmt.pc[0]), 32'(e0.pc));
      check("cmt.pc[1]", 32'(cmt.pc[1]), 32'(e1.pc));
      ent = '0;
      repeat (2) next_edge();
   endtask

   task automatic check_reg(logic [31:0] r);
      logic [`NCPU_LRF_AW-1:0] a;
      a = r[`NCPU_LRF_AW-1:0];
      next_edge();
      rf_raddr = a;
      #1;
      check($sformatf("shadow x%0d", a), rf_rdat, exp_rf[a]);
   endtask

   task automatic check_stat(logic [`CMT_W-1:0] fire, logic exc);
      check("cmt.fire", 32'(seen_fire), 32'(fire));
      check("cmt.exc", 32'(seen_exc), 32'(exc));
      check("commit_cnt", stat.commit_cnt, exp_commit);
      check("exc_cnt", 32'(stat.exc_cnt), exp_exc);
      check("last_exc_vect", stat.last_exc_vect, exp_vect);
      check("last_irr", 32'(stat.last_irr), exp_irr);
   endtask

   task automatic end_test(string name, int errs_before);
      test_cnt++;
      if (err_cnt == errs_before)
         $display("Test %s: ok", name);
      else
      begin
         test_fail++;
         $display("Test %s: %0d mismatches", name, err_cnt - errs_before);
      end
   endtask

   task automatic test_dual_retire();
      int          errs = err_cnt;
      logic [31:0] d0 = $urandom;
      logic [31:0] d1 = $urandom;
      commit_pair(build_entry(1'b1, 3, 1'b1, d0, NONE), build_entry(1'b1, 7, 1'b1, d1, NONE));
      exp_rf[3] = d0;
      exp_rf[7] = d1;
      exp_commit = exp_commit + 32'd2;
      check_stat(2'b11, 1'b0);
      check_reg(3);
      check_reg(7);
      // Same target in both lanes
      d0 = $urandom;
      d1 = $urandom;
      commit_pair(build_entry(1'b1, 9, 1'b1, d0, NONE), build_entry(1'b1, 9, 1'b1, d1, NONE));
      exp_rf[9] = d1;
      exp_commit = exp_commit + 32'd2;
      check_stat(2'b11, 1'b0);
      check_reg(9);
      end_test("dual_retire", errs);
   endtask

   task automatic test_lane0_exc();
      int errs = err_cnt;
      commit_pair(build_entry(1'b1, 3, 1'b1, $urandom, SYSCALL),
                  build_entry(1'b1, 7, 1'b1, $urandom, NONE));
      exp_exc = exp_exc + 32'd1;
      exp_vect = `EXC_VECT_BASE + 32'd32;
      check_stat(2'b00, 1'b1);
      check_reg(3);
      check_reg(7);
      end_test("lane0_exception", errs);
   endtask

   task automatic test_lane1_exc();
      int          errs = err_cnt;
      logic [31:0] d0 = $urandom;
      commit_pair(build_entry(1'b1, 14, 1'b1, d0, NONE),
                  build_entry(1'b1, 15, 1'b1, $urandom, ILLEGAL));
      exp_rf[14] = d0;
      exp_commit = exp_commit + 32'd1;
      exp_exc = exp_exc + 32'd1;
      exp_vect = `EXC_VECT_BASE + 32'd16;
      check_stat(2'b01, 1'b1);
      check_reg(14);
      check_reg(15);
      end_test("lane1_exception", errs);
   endtask

   task automatic test_stall();
      int          errs = err_cnt;
      logic [31:0] d0 = $urandom;
      logic [31:0] d1 = $urandom;
      next_edge();
      stall = 1'b1;
      ent[0] = build_entry(1'b1, 20, 1'b1, d0, NONE);
      ent[1] = build_entry(1'b1, 21, 1'b1, d1, NONE);
      repeat (5) next_edge();
      check("cmt.fire under stall", 32'(cmt.fire), 32'd0);
      check("commit_cnt under stall", stat.commit_cnt, exp_commit);
      check_reg(20);
      check_reg(21);
      // Release with the pair still held
      next_edge();
      stall = 1'b0;
      next_edge();
      seen_fire = cmt.fire;
      seen_exc = cmt.exc;
      check("cmt.pc[0]", 32'(cmt.pc[0]), 32'(ent[0].pc));
      check("cmt.pc[1]", 32'(cmt.pc[1]), 32'(ent[1].pc));
      ent = '0;
      repeat (4) next_edge();
      exp_rf[20] = d0;
      exp_rf[21] = d1;
      exp_commit = exp_commit + 32'd2;
      check_stat(2'b11, 1'b0);
      check_reg(20);
      check_reg(21);
      end_test("stall", errs);
   endtask

   task automatic test_interrupt();
      int errs = err_cnt;
      next_edge();
      msr_we = 1'b1;
      msr_wdat = 8'h04;
      next_edge();
      msr_we = 1'b0;
      irq = 8'h04;
      next_edge();
      irq = '0;
      commit_pair(build_entry(1'b1, 22, 1'b1, $urandom, NONE),
                  build_entry(1'b1, 23, 1'b1, $urandom, NONE));
      exp_exc = exp_exc + 32'd1;
      exp_vect = `EXC_VECT_BASE + 32'd48;
      exp_irr = 32'h04;
      check_stat(2'b00, 1'b1);
      check_reg(22);
      // Request was acknowledged, so this pair retires
      exp_rf[22] = $urandom;
      exp_rf[23] = $urandom;
      commit_pair(build_entry(1'b1, 22, 1'b1, exp_rf[22], NONE),
                  build_entry(1'b1, 23, 1'b1, exp_rf[23], NONE));
      exp_commit = exp_commit + 32'd2;
      check_stat(2'b11, 1'b0);
      check_reg(22);
      check_reg(23);
      // Masked-out line stays latched but never pends
      next_edge();
      irq = 8'h10;
      next_edge();
      irq = '0;
      exp_rf[24] = $urandom;
      commit_pair(build_entry(1'b1, 24, 1'b1, exp_rf[24], NONE),
                  build_entry(1'b1, 25, 1'b0, $urandom, NONE));
      exp_commit = exp_commit + 32'd2;
      check_stat(2'b11, 1'b0);
      check_reg(24);
      check_reg(25);
      end_test("interrupt", errs);
   endtask

   initial
   begin
      rst = 1'b1;
      ent = '0;
      stall = 1'b0;
      irq = '0;
      msr_we = 1'b0;
      msr_wdat = '0;
      rf_raddr = '0;
      exp_rf = '{default: '0};
      exp_commit = '0;
      exp_exc = '0;
      exp_vect = '0;
      exp_irr = '0;
      err_cnt = 0;
      test_cnt = 0;
      test_fail = 0;
      cycle_cnt = 0;
      void'($urandom(32'h5db9_d36d));
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      test_dual_retire();
      test_lane0_exc();
      test_lane1_exc();
      test_stall();
      test_interrupt();
      $display("Tests run %0d, failed %0d, mismatches %0d", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+rtl
rtl/ncpu_cmt_pkg.sv
rtl/difftest_pkg.sv
rtl/irq_ctrl.sv
rtl/cmt_unit.sv
rtl/difftest.sv
rtl/commit_tracer.sv
rtl/ncpu_commit_top.sv
test/tb_ncpu_commit.sv
